/* bpu_cfg_pkg.sv */
package bpu_cfg_pkg;

  // ================================================
  // Fetch addressing
  // ================================================

  // First fetch address out of reset
  localparam logic [31:0] RESET_PC = 32'h1c00_0000;

  // Byte offset bits of a two-instruction block
  localparam int BLOCK_OFS = 3;

  // ================================================
  // Table sizes
  // ================================================

  // BTB row index and stored tag
  localparam int BTB_ADDR_WIDTH = 6;
  localparam int BTB_TAG_WIDTH  = 8;
  localparam int BTB_ROWS       = 1 << BTB_ADDR_WIDTH;

  // Counter index per PHT bank
  localparam int PHT_ADDR_WIDTH = 6;
  localparam int PHT_ROWS       = 1 << PHT_ADDR_WIDTH;

  // Return stack entries and pointer width
  localparam int RAS_DEPTH     = 8;
  localparam int RAS_PTR_WIDTH = $clog2(RAS_DEPTH);

endpackage : bpu_cfg_pkg

/* bpu_types_pkg.sv */
package bpu_types_pkg;

  // ================================================
  // Branch classes stored in the BTB
  // ================================================

  // Plain jumps live as BR_COND with a strong counter
  typedef enum logic [1:0] {
    BR_NONE   = 2'b00,
    BR_COND   = 2'b01,
    BR_CALL   = 2'b10,
    BR_RETURN = 2'b11
  } br_type_e;

  // ================================================
  // 2-bit saturating counter
  // ================================================

  // Upper bit set means predict taken
  typedef enum logic [1:0] {
    STRONG_NT = 2'b00,
    WEAK_NT   = 2'b01,
    WEAK_T    = 2'b10,
    STRONG_T  = 2'b11
  } ctr_e;

  // Counter value after reset
  localparam ctr_e CTR_INIT = WEAK_NT;

endpackage : bpu_types_pkg

/* branch_target_buffer.sv */
module branch_target_buffer
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic [31:0]           rd_pc_i,
  input  logic                  wr_en_i,
  input  logic [31:0]           wr_pc_i,
  input  logic [31:0]           wr_target_i,
  input  br_type_e              wr_type_i,
  output logic [1:0][29:0]      target_o,
  output br_type_e [1:0]        type_o
);

  // ================================================
  // Address split
  // ================================================

  logic [BTB_ADDR_WIDTH-1:0] rd_idx;
  logic [BTB_TAG_WIDTH-1:0]  rd_tag;
  logic [BTB_ADDR_WIDTH-1:0] wr_idx;
  logic [BTB_TAG_WIDTH-1:0]  wr_tag;
  logic                      wr_slot;

  // Row from block address, tag from the bits right above it
  assign rd_idx  = rd_pc_i[BLOCK_OFS +: BTB_ADDR_WIDTH];
  assign rd_tag  = rd_pc_i[BLOCK_OFS + BTB_ADDR_WIDTH +: BTB_TAG_WIDTH];
  assign wr_idx  = wr_pc_i[BLOCK_OFS +: BTB_ADDR_WIDTH];
  assign wr_tag  = wr_pc_i[BLOCK_OFS + BTB_ADDR_WIDTH +: BTB_TAG_WIDTH];
  // Word bit inside the block picks the entry
  assign wr_slot = wr_pc_i[2];

  // ================================================
  // Storage, one entry per slot per row
  // ================================================

  logic [BTB_TAG_WIDTH-1:0] tag_mem    [2][BTB_ROWS];
  logic [29:0]              target_mem [2][BTB_ROWS];
  br_type_e                 type_mem   [2][BTB_ROWS];
  logic [1:0][BTB_ROWS-1:0] valid_q;
  logic [1:0]               rd_hit;

  // Payload arrays
  always_ff @(posedge clk) begin
    if (wr_en_i) begin
      tag_mem[wr_slot][wr_idx]    <= wr_tag;
      target_mem[wr_slot][wr_idx] <= wr_target_i[31:2];
      type_mem[wr_slot][wr_idx]   <= wr_type_i;
    end
  end

  // Valid bits, writing BR_NONE drops the entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (wr_en_i) begin
      valid_q[wr_slot][wr_idx] <= (wr_type_i != BR_NONE);
    end
  end

  // ================================================
  // Synchronous read
  // ================================================

  // Tag compare on the row being read
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      rd_hit[s] = valid_q[s][rd_idx] && (tag_mem[s][rd_idx] == rd_tag);
    end
  end

  // Target is payload
  always_ff @(posedge clk) begin
    for (int s = 0; s < 2; s++) begin
      target_o[s] <= target_mem[s][rd_idx];
    end
  end

  // Type doubles as hit flag
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      type_o <= {BR_NONE, BR_NONE};
    end else begin
      for (int s = 0; s < 2; s++) begin
        type_o[s] <= rd_hit[s] ? type_mem[s][rd_idx] : BR_NONE;
      end
    end
  end

  // Back end only trains word aligned targets
  a_wr_target_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en_i |-> (wr_target_i[1:0] == 2'b00)
  ) else $error("btb write target not word aligned");

endmodule : branch_target_buffer

/* pattern_history_table.sv */
module pattern_history_table
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  logic                      clk,
  input  logic                      rst_n,
  input  logic [PHT_ADDR_WIDTH-1:0] rd_index_i,
  input  logic [PHT_ADDR_WIDTH-1:0] wr_index_i,
  input  logic                      we_i,
  input  logic                      taken_i,
  input  ctr_e                      ctr_i,
  output ctr_e                      ctr_o
);

  // ================================================
  // Counter update
  // ================================================

  ctr_e ctr_mem [PHT_ROWS];
  ctr_e ctr_next;

  // One step toward the outcome, held at both ends
  always_comb begin
    ctr_next = ctr_i;
    unique case (ctr_i)
      STRONG_NT: ctr_next = taken_i ? WEAK_NT  : STRONG_NT;
      WEAK_NT:   ctr_next = taken_i ? WEAK_T   : STRONG_NT;
      WEAK_T:    ctr_next = taken_i ? STRONG_T : WEAK_NT;
      STRONG_T:  ctr_next = taken_i ? STRONG_T : WEAK_T;
      default:   ctr_next = CTR_INIT;
    endcase
  end

  // ================================================
  // Counter bank
  // ================================================

  // All counters start weakly not taken
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < PHT_ROWS; i++) begin
        ctr_mem[i] <= CTR_INIT;
      end
    end else if (we_i) begin
      ctr_mem[wr_index_i] <= ctr_next;
    end
  end

  // Read sees the old value on a same-edge write
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ctr_o <= CTR_INIT;
    end else begin
      ctr_o <= ctr_mem[rd_index_i];
    end
  end

endmodule : pattern_history_table

/* return_address_stack.sv */
module return_address_stack
  import bpu_cfg_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  input  logic                     push_i,
  input  logic                     pop_i,
  input  logic [29:0]              push_addr_i,
  input  logic                     restore_i,
  input  logic [RAS_PTR_WIDTH-1:0] restore_ptr_i,
  output logic [29:0]              top_o,
  output logic [RAS_PTR_WIDTH-1:0] ptr_o
);

  // ================================================
  // Pointer arithmetic
  // ================================================

  logic [29:0]              stk_q [RAS_DEPTH];
  logic [RAS_PTR_WIDTH-1:0] ptr_q;
  logic [RAS_PTR_WIDTH-1:0] ptr_inc;
  logic [RAS_PTR_WIDTH-1:0] ptr_dec;

  // Pointer names the next free entry
  // Explicit wrap so depth need not be a power of two
  always_comb begin
    if (ptr_q == RAS_PTR_WIDTH'(RAS_DEPTH - 1)) begin
      ptr_inc = '0;
    end else begin
      ptr_inc = ptr_q + 1'b1;
    end
    if (ptr_q == '0) begin
      ptr_dec = RAS_PTR_WIDTH'(RAS_DEPTH - 1);
    end else begin
      ptr_dec = ptr_q - 1'b1;
    end
  end

  // ================================================
  // Stack state
  // ================================================

  // Restore wins, entries themselves are left alone
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ptr_q <= '0;
    end else if (restore_i) begin
      ptr_q <= restore_ptr_i;
    end else if (push_i) begin
      ptr_q <= ptr_inc;
    end else if (pop_i) begin
      ptr_q <= ptr_dec;
    end
  end

  // Overflow overwrites the oldest entry
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < RAS_DEPTH; i++) begin
        stk_q[i] <= '0;
      end
    end else if (push_i && !restore_i) begin
      stk_q[ptr_q] <= push_addr_i;
    end
  end

  // Top of stack straight from the array
  assign top_o = stk_q[ptr_dec];
  assign ptr_o = ptr_q;

  // One predicted slot cannot be both call and return
  a_push_pop_excl : assert property (
    @(posedge clk) disable iff (!rst_n)
    !(push_i && pop_i)
  ) else $error("ras push and pop in the same cycle");

endmodule : return_address_stack

/* branch_prediction_unit.sv */
module branch_prediction_unit
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
(
  input  logic                     clk,
  input  logic                     rst_n,
  // Fetch side
  input  logic                     next_i,
  // Back-end correction
  input  logic                     redirect_i,
  input  logic [31:0]              redirect_pc_i,
  // Training
  input  logic                     btb_update_i,
  input  logic                     pht_update_i,
  input  logic [31:0]              upd_pc_i,
  input  logic [31:0]              upd_target_i,
  input  br_type_e                 upd_type_i,
  input  logic                     upd_taken_i,
  input  ctr_e                     upd_ctr_i,
  input  logic                     ras_restore_i,
  input  logic [RAS_PTR_WIDTH-1:0] ras_ptr_i,
  // Prediction
  output logic [31:0]              fetch_pc_o,
  output logic [1:0]               slot_valid_o,
  output logic                     pred_taken_o,
  output logic                     pred_slot_o,
  output br_type_e                 pred_type_o,
  output ctr_e                     pred_ctr_o,
  output logic [RAS_PTR_WIDTH-1:0] ras_ptr_o,
  output logic [31:0]              next_pc_o
);

  logic [31:0]              pc_q;
  logic [31:0]              npc;
  logic [31:0]              pred_pc;
  logic [1:0][29:0]         btb_target;
  br_type_e [1:0]           btb_type;
  ctr_e                     pht_ctr [2];
  logic [PHT_ADDR_WIDTH-1:0] pht_rd_idx;
  logic [PHT_ADDR_WIDTH-1:0] pht_wr_idx;
  logic [1:0]               slot_take;
  logic                     taken0;
  logic                     taken1;
  logic                     pred_slot;
  logic                     ras_push;
  logic                     ras_pop;
  logic [29:0]              ras_push_addr;
  logic [29:0]              ras_top;

  // ================================================
  // Fetch PC
  // ================================================

  // Redirect beats back-pressure, stall holds the PC
  assign npc = redirect_i ? redirect_pc_i :
               next_i     ? pred_pc       :
                            pc_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= npc;
    end
  end

  // ================================================
  // Tables, all read at the next PC
  // ================================================

  branch_target_buffer btb_u (
    .clk         (clk),
    .rst_n       (rst_n),
    .rd_pc_i     (npc),
    .wr_en_i     (btb_update_i),
    .wr_pc_i     (upd_pc_i),
    .wr_target_i (upd_target_i),
    .wr_type_i   (upd_type_i),
    .target_o    (btb_target),
    .type_o      (btb_type)
  );

  // Same block index for both banks
  assign pht_rd_idx = npc[BLOCK_OFS +: PHT_ADDR_WIDTH];
  assign pht_wr_idx = upd_pc_i[BLOCK_OFS +: PHT_ADDR_WIDTH];

  // Bank 0 trains on slot 0 only
  pattern_history_table pht_bank0_u (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_index_i (pht_rd_idx),
    .wr_index_i (pht_wr_idx),
    .we_i       (pht_update_i & ~upd_pc_i[2]),
    .taken_i    (upd_taken_i),
    .ctr_i      (upd_ctr_i),
    .ctr_o      (pht_ctr[0])
  );

  // Bank 1 trains on slot 1 only
  pattern_history_table pht_bank1_u (
    .clk        (clk),
    .rst_n      (rst_n),
    .rd_index_i (pht_rd_idx),
    .wr_index_i (pht_wr_idx),
    .we_i       (pht_update_i & upd_pc_i[2]),
    .taken_i    (upd_taken_i),
    .ctr_i      (upd_ctr_i),
    .ctr_o      (pht_ctr[1])
  );

  // Return address is the word after the call slot
  assign ras_push_addr = {pc_q[31:BLOCK_OFS], pred_slot} + 30'd1;
  // Nothing moves on a stalled or squashed block
  assign ras_push = next_i & ~redirect_i & (pred_type_o == BR_CALL);
  assign ras_pop  = next_i & ~redirect_i & (pred_type_o == BR_RETURN);

  return_address_stack ras_u (
    .clk           (clk),
    .rst_n         (rst_n),
    .push_i        (ras_push),
    .pop_i         (ras_pop),
    .push_addr_i   (ras_push_addr),
    .restore_i     (ras_restore_i),
    .restore_ptr_i (ras_ptr_i),
    .top_o         (ras_top),
    .ptr_o         (ras_ptr_o)
  );

  // ================================================
  // Prediction
  // ================================================

  // Calls and returns always jump, COND follows the counter
  always_comb begin
    for (int s = 0; s < 2; s++) begin
      slot_take[s] = (btb_type[s] == BR_CALL) || (btb_type[s] == BR_RETURN) ||
                     ((btb_type[s] == BR_COND) && pht_ctr[s][1]);
    end
  end

  // Slot 0 dead when entering at the odd word
  assign taken0    = slot_take[0] & ~pc_q[2];
  assign taken1    = slot_take[1];
  // Last slot when slot 0 does not take
  assign pred_slot = ~taken0;

  always_comb begin
    pred_taken_o = taken0 | taken1;
    pred_slot_o  = pred_slot;
    pred_type_o  = pred_taken_o ? btb_type[pred_slot] : BR_NONE;
    pred_ctr_o   = pht_ctr[pred_slot];
    // Fall through to the next aligned block
    if (pred_type_o == BR_RETURN) begin
      pred_pc = {ras_top, 2'b00};
    end else if (pred_taken_o) begin
      pred_pc = {btb_target[pred_slot], 2'b00};
    end else begin
      pred_pc = {pc_q[31:BLOCK_OFS] + 1'b1, {BLOCK_OFS{1'b0}}};
    end
  end

  // Slot 1 is cut off by a taken slot 0
  assign slot_valid_o[0] = next_i & ~pc_q[2];
  assign slot_valid_o[1] = next_i & ~taken0;

  assign fetch_pc_o = pc_q;
  assign next_pc_o  = npc;

  // Holds over redirects and trained targets alike
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    fetch_pc_o[1:0] == 2'b00
  ) else $error("fetch pc not word aligned");

endmodule : branch_prediction_unit

/* bpu_clk_gen.sv */
module bpu_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);

  localparam int HALF_PERIOD  = 4;
  localparam int RESET_CYCLES = 16;

  // Free running clock, 8 units per period
  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

  // Reset released on a rising edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule : bpu_clk_gen

/* bpu_tb.sv */
module bpu_tb
  import bpu_cfg_pkg::*;
  import bpu_types_pkg::*;
();

  // ================================================
  // Addresses and limits
  // ================================================

  localparam logic [31:0] PARK_PC = 32'h1c00_01f8;
  localparam logic [31:0] ODD_PC  = 32'h1c00_0104;
  // COND in slot 0
  localparam logic [31:0] B2_PC   = 32'h1c01_0080;
  localparam logic [31:0] T2_PC   = 32'h1c00_4040;
  // COND in slot 1
  localparam logic [31:0] B3_PC   = 32'h1c01_0090;
  localparam logic [31:0] T3_PC   = 32'h1c00_4080;
  // CALL in slot 1, callee has CALL in slot 0 and RETURN in slot 1
  localparam logic [31:0] C1_PC   = 32'h1c01_00a0;
  localparam logic [31:0] F1_PC   = 32'h1c01_0100;
  localparam logic [31:0] F2_PC   = 32'h1c01_0180;
  localparam int          PC_TIMEOUT  = 20;
  localparam int          RST_TIMEOUT = 100;

  typedef struct packed {
    logic [1:0]  valid;
    logic        taken;
    logic        slot;
    br_type_e    ptype;
    ctr_e        ctr;
    logic [31:0] npc;
  } pred_t;

  logic                     clk;
  logic                     rst_n;
  logic                     next_i;
  logic                     redirect_i;
  logic [31:0]              redirect_pc_i;
  logic                     btb_update_i;
  logic                     pht_update_i;
  logic [31:0]              upd_pc_i;
  logic [31:0]              upd_target_i;
  br_type_e                 upd_type_i;
  logic                     upd_taken_i;
  ctr_e                     upd_ctr_i;
  logic                     ras_restore_i;
  logic [RAS_PTR_WIDTH-1:0] ras_ptr_i;
  logic [31:0]              fetch_pc_o;
  logic [1:0]               slot_valid_o;
  logic                     pred_taken_o;
  logic                     pred_slot_o;
  br_type_e                 pred_type_o;
  ctr_e                     pred_ctr_o;
  logic [RAS_PTR_WIDTH-1:0] ras_ptr_o;
  logic [31:0]              next_pc_o;

  // Reference copies of every table
  logic [BTB_TAG_WIDTH-1:0] btb_tag_m  [2][BTB_ROWS];
  logic [31:0]              btb_tgt_m  [2][BTB_ROWS];
  br_type_e                 btb_type_m [2][BTB_ROWS];
  logic                     btb_val_m  [2][BTB_ROWS];
  ctr_e                     pht_m      [2][PHT_ROWS];
  logic [31:0]              ras_m      [RAS_DEPTH];
  int                       ras_ptr_m;
  logic [31:0]              pc_m;
  pred_t                    exp_q;
  logic [31:0]              lfsr_q;
  int                       n_checks;
  int                       n_errors;

  bpu_clk_gen clk_gen_u (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  branch_prediction_unit branch_prediction_unit_i (.*);

  // ================================================
  // Random source and reference rules
  // ================================================

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[30:0], lfsr_q[0]};
    end
    return v;
  endfunction

  // Saturating step toward the outcome
  function automatic ctr_e ctr_step(input ctr_e c, input logic taken);
    if (taken) begin
      return (c == STRONG_T) ? c : ctr_e'(c + 2'd1);
    end
    return (c == STRONG_NT) ? c : ctr_e'(c - 2'd1);
  endfunction

  function automatic pred_t predict(input logic [31:0] pc, input logic nxt,
                                    input logic redir, input logic [31:0] rpc);
    pred_t       p;
    int          row;
    int          pidx;
    br_type_e    ty [2];
    logic [1:0]  take;
    logic        t0;
    logic [31:0] tgt;
    row  = pc[BLOCK_OFS +: BTB_ADDR_WIDTH];
    pidx = pc[BLOCK_OFS +: PHT_ADDR_WIDTH];
    for (int s = 0; s < 2; s++) begin
      ty[s] = BR_NONE;
      if (btb_val_m[s][row] &&
          btb_tag_m[s][row] == pc[BLOCK_OFS + BTB_ADDR_WIDTH +: BTB_TAG_WIDTH]) begin
        ty[s] = btb_type_m[s][row];
      end
      take[s] = (ty[s] == BR_CALL) || (ty[s] == BR_RETURN) ||
                (ty[s] == BR_COND && pht_m[s][pidx] >= WEAK_T);
    end
    // Slot 0 lies before the entry point on an odd word
    t0      = take[0] && !pc[2];
    p.taken = t0 || take[1];
    p.slot  = !t0;
    p.ptype = p.taken ? ty[p.slot] : BR_NONE;
    p.ctr   = pht_m[p.slot][pidx];
    p.valid = {nxt && !t0, nxt && !pc[2]};
    if (p.ptype == BR_RETURN) begin
      tgt = ras_m[(ras_ptr_m + RAS_DEPTH - 1) % RAS_DEPTH];
    end else if (p.taken) begin
      tgt = btb_tgt_m[p.slot][row];
    end else begin
      tgt = {pc[31:BLOCK_OFS], {BLOCK_OFS{1'b0}}} + (1 << BLOCK_OFS);
    end
    p.npc = redir ? rpc : (nxt ? tgt : pc);
    return p;
  endfunction

  task automatic reset_model();
    for (int s = 0; s < 2; s++) begin
      for (int r = 0; r < BTB_ROWS; r++) begin
        btb_val_m[s][r] = 1'b0;
      end
      for (int r = 0; r < PHT_ROWS; r++) begin
        pht_m[s][r] = WEAK_NT;
      end
    end
    for (int i = 0; i < RAS_DEPTH; i++) begin
      ras_m[i] = '0;
    end
    ras_ptr_m   = 0;
    pc_m        = RESET_PC;
    exp_q       = '0;
    exp_q.ptype = BR_NONE;
  endtask

  // ================================================
  // Model update and output compare
  // ================================================

  // Strobes seen here with the same values the DUT samples
  always @(posedge clk) begin : model_update
    int row;
    int bank;
    if (!rst_n) begin
      reset_model();
    end else begin
      if (btb_update_i) begin
        bank = upd_pc_i[2];
        row  = upd_pc_i[BLOCK_OFS +: BTB_ADDR_WIDTH];
        btb_tag_m[bank][row]  = upd_pc_i[BLOCK_OFS + BTB_ADDR_WIDTH +: BTB_TAG_WIDTH];
        btb_tgt_m[bank][row]  = upd_target_i;
        btb_type_m[bank][row] = upd_type_i;
        btb_val_m[bank][row]  = (upd_type_i != BR_NONE);
      end
      if (pht_update_i) begin
        bank = upd_pc_i[2];
        row  = upd_pc_i[BLOCK_OFS +: PHT_ADDR_WIDTH];
        pht_m[bank][row] = ctr_step(upd_ctr_i, upd_taken_i);
      end
      // Stack only moves for a consumed, unsquashed block
      if (ras_restore_i) begin
        ras_ptr_m = ras_ptr_i;
      end else if (next_i && !redirect_i && exp_q.ptype == BR_CALL) begin
        ras_m[ras_ptr_m] = {pc_m[31:BLOCK_OFS], exp_q.slot, 2'b00} + 32'd4;
        ras_ptr_m = (ras_ptr_m + 1) % RAS_DEPTH;
      end else if (next_i && !redirect_i && exp_q.ptype == BR_RETURN) begin
        ras_ptr_m = (ras_ptr_m + RAS_DEPTH - 1) % RAS_DEPTH;
      end
      pc_m = exp_q.npc;
    end
  end

  always @(negedge clk) begin
    if (rst_n) begin
      exp_q = predict(pc_m, next_i, redirect_i, redirect_pc_i);
      check("fetch_pc_o", fetch_pc_o, pc_m);
      check("slot_valid_o", slot_valid_o, exp_q.valid);
      check("pred_taken_o", pred_taken_o, exp_q.taken);
      check("pred_slot_o", pred_slot_o, exp_q.slot);
      check("pred_type_o", pred_type_o, exp_q.ptype);
      check("pred_ctr_o", pred_ctr_o, exp_q.ctr);
      check("ras_ptr_o", ras_ptr_o, ras_ptr_m);
      check("next_pc_o", next_pc_o, exp_q.npc);
    end
  end

  task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("error at %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic finish_run();
    $display("checks: %0d errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("checks: %0d errors: %0d", n_checks, n_errors);
    $display("RESULT: FAIL");
    $finish;
  endtask

  // ================================================
  // Stimulus helpers
  // ================================================

  task automatic wait_pc(input logic [31:0] addr);
    int n;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (fetch_pc_o !== addr && n < PC_TIMEOUT);
    if (fetch_pc_o !== addr) abort_run($sformatf("fetch pc never reached %h", addr));
  endtask

  task automatic train_btb(input logic [31:0] pc, input logic [31:0] tgt, input br_type_e ty);
    @(posedge clk);
    btb_update_i <= 1'b1;
    upd_pc_i     <= pc;
    upd_target_i <= tgt;
    upd_type_i   <= ty;
    @(posedge clk);
    btb_update_i <= 1'b0;
  endtask

  task automatic train_pht(input logic [31:0] pc, input logic taken);
    @(posedge clk);
    pht_update_i <= 1'b1;
    upd_pc_i     <= pc;
    upd_taken_i  <= taken;
    // Old counter as the fetch side returned it
    upd_ctr_i    <= pht_m[pc[2]][pc[BLOCK_OFS +: PHT_ADDR_WIDTH]];
    @(posedge clk);
    pht_update_i <= 1'b0;
  endtask

  task automatic visit(input logic [31:0] addr);
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= addr;
    next_i        <= 1'b1;
    // Redirect wins over the predicted path
    @(negedge clk);
    check("redirect next_pc_o", next_pc_o, addr);
    @(posedge clk);
    redirect_i <= 1'b0;
    wait_pc(addr);
  endtask

  // Stalled on a row that is never trained
  task automatic park();
    @(posedge clk);
    redirect_i    <= 1'b1;
    redirect_pc_i <= PARK_PC;
    next_i        <= 1'b0;
    @(posedge clk);
    redirect_i <= 1'b0;
  endtask

  // ================================================
  // Test sequence
  // ================================================

  initial begin : stimulus
    int   n;
    ctr_e nt_seq [4];
    nt_seq = '{WEAK_T, WEAK_NT, STRONG_NT, STRONG_NT};
    lfsr_q = 32'h6190;
    n_checks = 0;
    n_errors = 0;
    next_i = 1'b0;
    redirect_i = 1'b0;
    redirect_pc_i = RESET_PC;
    btb_update_i = 1'b0;
    pht_update_i = 1'b0;
    upd_pc_i = '0;
    upd_target_i = '0;
    upd_type_i = BR_NONE;
    upd_taken_i = 1'b0;
    upd_ctr_i = WEAK_NT;
    ras_restore_i = 1'b0;
    ras_ptr_i = '0;
    n = 0;
    while (!rst_n && n < RST_TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (!rst_n) abort_run("reset was never released");

    // Empty tables, sequential fetch with random stalls
    for (int i = 0; i < 40; i++) begin
      @(posedge clk);
      next_i <= (rand_bits(2) != 0);
    end
    visit(ODD_PC);
    check("odd word slot_valid_o", slot_valid_o, 2'b10);
    park();

    // COND entries trained taken
    train_btb(B2_PC, T2_PC, BR_COND);
    train_pht(B2_PC, 1'b1);
    train_pht(B2_PC, 1'b1);
    train_btb(B3_PC + 4, T3_PC, BR_COND);
    repeat (4) train_pht(B3_PC + 4, 1'b1);
    visit(B2_PC);
    check("b2 slot_valid_o", slot_valid_o, 2'b01);
    check("b2 pred_slot_o", pred_slot_o, 1'b0);
    check("b2 next_pc_o", next_pc_o, T2_PC);
    park();
    visit(B3_PC);
    check("b3 pred_slot_o", pred_slot_o, 1'b1);
    check("b3 pred_ctr_o", pred_ctr_o, STRONG_T);
    check("b3 next_pc_o", next_pc_o, T3_PC);
    park();

    // Not-taken outcomes walk the counter down to the floor
    for (int k = 0; k < 4; k++) begin
      train_pht(B3_PC + 4, 1'b0);
      visit(B3_PC);
      check("b3 pred_taken_o", pred_taken_o, k == 0);
      check("b3 pred_ctr_o", pred_ctr_o, nt_seq[k]);
      park();
    end

    // Nested call and return
    train_btb(C1_PC + 4, F1_PC, BR_CALL);
    train_btb(F1_PC, F2_PC, BR_CALL);
    train_btb(F1_PC + 4, '0, BR_RETURN);
    train_btb(F2_PC, '0, BR_RETURN);
    visit(C1_PC);
    check("call pred_type_o", pred_type_o, BR_CALL);
    wait_pc(F1_PC);
    check("inner call slot_valid_o", slot_valid_o, 2'b01);
    wait_pc(F2_PC);
    check("inner return next_pc_o", next_pc_o, F1_PC + 4);
    wait_pc(F1_PC + 4);
    check("outer return next_pc_o", next_pc_o, C1_PC + 8);
    wait_pc(C1_PC + 8);
    check("unwound ras_ptr_o", ras_ptr_o, 0);
    park();

    // Pointer restore from the back end
    @(posedge clk);
    ras_restore_i <= 1'b1;
    ras_ptr_i     <= RAS_PTR_WIDTH'(5);
    @(posedge clk);
    ras_restore_i <= 1'b0;
    @(negedge clk);
    check("restored ras_ptr_o", ras_ptr_o, 5);

    // Random redirects into the trained region, tables now fixed
    for (int i = 0; i < 150; i++) begin
      @(posedge clk);
      redirect_i    <= (rand_bits(3) == 0);
      redirect_pc_i <= 32'h1c01_0000 + (rand_bits(7) << 2);
      next_i        <= (rand_bits(1) != 0);
    end
    @(posedge clk);
    redirect_i <= 1'b0;
    next_i     <= 1'b0;
    repeat (2) @(posedge clk);
    finish_run();
  end

endmodule : bpu_tb

/* compile.f */
bpu_cfg_pkg.sv
bpu_types_pkg.sv
branch_target_buffer.sv
pattern_history_table.sv
return_address_stack.sv
branch_prediction_unit.sv
bpu_clk_gen.sv
bpu_tb.sv
